// ==== source/axi_burst_config.svh ====
`ifndef AXI_BURST_CONFIG_SVH
`define AXI_BURST_CONFIG_SVH

// Bus widths
`define BRIDGE_ADDR_W 16
`define BRIDGE_DATA_W 32

// Max burst of 2**AXI_LEN_W beats, also the FIFO depth
`define AXI_LEN_W 4

`define BRIDGE_COUNT_W 12

// Cycles a partial burst may wait before it goes out
`define FLUSH_WAIT 15

`endif

// ==== source/axi_pkg.sv ====
`include "axi_burst_config.svh"

package axi_pkg;

   // Beats minus one, as carried on awlen and arlen
   typedef logic [`AXI_LEN_W-1:0] axi_len_t;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } axi_resp_e;

endpackage

// ==== source/bridge_pkg.sv ====
`include "axi_burst_config.svh"

package bridge_pkg;

   typedef logic [`BRIDGE_DATA_W-1:0] word_t;
   typedef logic [`BRIDGE_DATA_W/8-1:0] strb_t;
   typedef logic [`BRIDGE_COUNT_W-1:0] count_t;

   typedef enum logic {
      DIR_READ  = 1'b0,
      DIR_WRITE = 1'b1
   } dir_e;

   // Byte address, or split up for the 4K page check
   typedef union packed {
      logic [`BRIDGE_ADDR_W-1:0] flat;
      struct packed {
         logic [3:0] page;
         logic [9:0] word;
         logic [1:0] offset;
      } fields;
   } bridge_addr_u;

endpackage

// ==== source/sync_fifo.sv ====
`timescale 1ns/1ns
`include "axi_burst_config.svh"

module sync_fifo #(
   parameter int WIDTH     = `BRIDGE_DATA_W,
   parameter int DEPTH_LOG = `AXI_LEN_W
) (
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  logic                 push_i,
   input  logic [WIDTH-1:0]     push_data_i,
   output logic                 full_o,
   input  logic                 pop_i,
   output logic [WIDTH-1:0]     pop_data_o,
   output logic                 empty_o,
   output logic [DEPTH_LOG:0]   level_o
);

   localparam int DEPTH = 1 << DEPTH_LOG;

   logic [WIDTH-1:0]     mem [DEPTH];
   logic [DEPTH_LOG-1:0] wr_ptr;
   logic [DEPTH_LOG-1:0] rd_ptr;
   logic                 do_push;
   logic                 do_pop;

   // Level tops out at DEPTH, so the MSB alone marks full
   assign full_o     = level_o[DEPTH_LOG];
   assign empty_o    = level_o == '0;
   assign do_push    = push_i & ~full_o;
   assign do_pop     = pop_i & ~empty_o;
   assign pop_data_o = mem[rd_ptr];

   always_ff @(posedge clk_i) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data_i;
      end
   end

   always_ff @(posedge clk_i, posedge rst_i) begin
      if (rst_i) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         level_o <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (do_push && !do_pop) begin
            level_o <= level_o + 1'b1;
         end else if (do_pop && !do_push) begin
            level_o <= level_o - 1'b1;
         end
      end
   end

endmodule

// ==== source/axi_read_engine.sv ====
`timescale 1ns/1ns
`include "axi_burst_config.svh"

module axi_read_engine
   import axi_pkg::*, bridge_pkg::*;
(
   input  logic                      clk_i,
   input  logic                      rst_i,
   input  logic                      run_i,
   input  bridge_addr_u              addr_i,
   input  axi_len_t                  len_i,
   output logic                      ready_o,
   output logic                      error_o,
   output logic                      arvalid_o,
   input  logic                      arready_i,
   output logic [`BRIDGE_ADDR_W-1:0] araddr_o,
   output axi_len_t                  arlen_o,
   input  logic                      rvalid_i,
   output logic                      rready_o,
   input  word_t                     rdata_i,
   input  axi_resp_e                 rresp_i,
   input  logic                      rlast_i,
   output logic                      push_o,
   output word_t                     push_data_o
);

   localparam logic [1:0] ST_IDLE = 2'd0;
   localparam logic [1:0] ST_ADDR = 2'd1;
   localparam logic [1:0] ST_DATA = 2'd2;

   logic [1:0] state;
   logic       beat_ok;

   assign ready_o   = state == ST_IDLE;
   assign arvalid_o = state == ST_ADDR;
   // Space in the output FIFO was reserved before the burst went out
   assign rready_o    = state == ST_DATA;
   assign beat_ok     = rvalid_i & rready_o;
   assign push_o      = beat_ok;
   assign push_data_o = rdata_i;

   always_ff @(posedge clk_i) begin
      if (run_i && state == ST_IDLE) begin
         araddr_o <= addr_i.flat;
         arlen_o  <= len_i;
      end
   end

   always_ff @(posedge clk_i, posedge rst_i) begin
      if (rst_i) begin
         state   <= ST_IDLE;
         error_o <= 1'b0;
      end else begin
         // One cycle flag per bad beat
         error_o <= beat_ok && rresp_i != OKAY;
         case (state)
            ST_IDLE: begin
               if (run_i) begin
                  state <= ST_ADDR;
               end
            end
            ST_ADDR: begin
               if (arready_i) begin
                  state <= ST_DATA;
               end
            end
            ST_DATA: begin
               if (beat_ok && rlast_i) begin
                  state <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

endmodule

// ==== source/axi_write_engine.sv ====
`timescale 1ns/1ns
`include "axi_burst_config.svh"

module axi_write_engine
   import axi_pkg::*, bridge_pkg::*;
(
   input  logic                      clk_i,
   input  logic                      rst_i,
   input  logic                      run_i,
   input  bridge_addr_u              addr_i,
   input  axi_len_t                  len_i,
   output logic                      ready_o,
   output logic                      error_o,
   output logic                      awvalid_o,
   input  logic                      awready_i,
   output logic [`BRIDGE_ADDR_W-1:0] awaddr_o,
   output axi_len_t                  awlen_o,
   output logic                      wvalid_o,
   input  logic                      wready_i,
   output word_t                     wdata_o,
   output strb_t                     wstrb_o,
   output logic                      wlast_o,
   input  logic                      bvalid_i,
   output logic                      bready_o,
   input  axi_resp_e                 bresp_i,
   output logic                      pop_o,
   input  word_t                     pop_data_i,
   input  strb_t                     pop_strb_i
);

   localparam logic [1:0] ST_IDLE = 2'd0;
   localparam logic [1:0] ST_ADDR = 2'd1;
   localparam logic [1:0] ST_DATA = 2'd2;
   localparam logic [1:0] ST_RESP = 2'd3;

   logic [1:0] state;
   axi_len_t   beat;
   logic       beat_ok;

   assign ready_o   = state == ST_IDLE;
   assign awvalid_o = state == ST_ADDR;
   assign bready_o  = state == ST_RESP;

   // W payload comes straight from the FIFO head
   assign wvalid_o = state == ST_DATA;
   assign wdata_o  = pop_data_i;
   assign wstrb_o  = pop_strb_i;
   assign wlast_o  = wvalid_o && beat == awlen_o;
   assign beat_ok  = wvalid_o & wready_i;
   assign pop_o    = beat_ok;

   always_ff @(posedge clk_i) begin
      if (run_i && state == ST_IDLE) begin
         awaddr_o <= addr_i.flat;
         awlen_o  <= len_i;
      end
   end

   always_ff @(posedge clk_i, posedge rst_i) begin
      if (rst_i) begin
         state   <= ST_IDLE;
         beat    <= '0;
         error_o <= 1'b0;
      end else begin
         error_o <= bvalid_i && bready_o && bresp_i != OKAY;
         case (state)
            ST_IDLE: begin
               beat <= '0;
               if (run_i) begin
                  state <= ST_ADDR;
               end
            end
            ST_ADDR: begin
               if (awready_i) begin
                  state <= ST_DATA;
               end
            end
            ST_DATA: begin
               if (beat_ok) begin
                  beat <= beat + 1'b1;
                  if (wlast_o) begin
                     state <= ST_RESP;
                  end
               end
            end
            default: begin
               if (bvalid_i) begin
                  state <= ST_IDLE;
               end
            end
         endcase
      end
   end

endmodule

// ==== source/axi_burst_bridge.sv ====
`timescale 1ns/1ns
`include "axi_burst_config.svh"

module axi_burst_bridge
   import axi_pkg::*, bridge_pkg::*;
(
   input  logic                      clk_i,
   input  logic                      rst_i,
   input  logic                      run_i,
   input  dir_e                      dir_i,
   input  bridge_addr_u              addr_i,
   input  count_t                    count_i,
   output logic                      ready_o,
   output logic                      error_o,
   input  logic                      s_valid_i,
   input  word_t                     s_wdata_i,
   input  strb_t                     s_wstrb_i,
   output word_t                     s_rdata_o,
   output logic                      s_ready_o,
   output logic                      awvalid_o,
   input  logic                      awready_i,
   output logic [`BRIDGE_ADDR_W-1:0] awaddr_o,
   output axi_len_t                  awlen_o,
   output logic                      wvalid_o,
   input  logic                      wready_i,
   output word_t                     wdata_o,
   output strb_t                     wstrb_o,
   output logic                      wlast_o,
   input  logic                      bvalid_i,
   output logic                      bready_o,
   input  axi_resp_e                 bresp_i,
   output logic                      arvalid_o,
   input  logic                      arready_i,
   output logic [`BRIDGE_ADDR_W-1:0] araddr_o,
   output axi_len_t                  arlen_o,
   input  logic                      rvalid_i,
   output logic                      rready_o,
   input  word_t                     rdata_i,
   input  axi_resp_e                 rresp_i,
   input  logic                      rlast_i
);

   localparam int STRB_W  = `BRIDGE_DATA_W / 8;
   localparam int BEAT_W  = `AXI_LEN_W + 1;
   localparam int FLUSH_W = $clog2(`FLUSH_WAIT + 1);
   localparam logic [BEAT_W-1:0] MAX_BEATS = BEAT_W'(1 << `AXI_LEN_W);

   logic                      busy_q;
   dir_e                      dir_q;
   bridge_addr_u              cur_addr;
   count_t                    remaining;
   logic [FLUSH_W-1:0]        flush_cnt;
   logic                      err_q;
   logic                      run_ok;
   logic                      in_full, out_empty;
   logic [BEAT_W-1:0]         in_level, out_level, avail;
   logic [`BRIDGE_DATA_W+STRB_W-1:0] in_head;
   logic                      wr_pop, rd_push;
   word_t                     rd_push_data;
   logic                      rd_ready, wr_ready, rd_err, wr_err;
   logic                      eng_ready, flush_done, issue;
   logic [10:0]               page_left;
   logic [BEAT_W-1:0]         limit, burst_words;
   axi_len_t                  burst_len;
   logic [13:0]               next_word;

   assign ready_o   = ~busy_q;
   assign error_o   = err_q;
   assign run_ok    = run_i & ~busy_q;
   assign s_ready_o = |s_wstrb_i ? ~in_full : ~out_empty;

   sync_fifo #(.WIDTH(`BRIDGE_DATA_W + STRB_W), .DEPTH_LOG(`AXI_LEN_W)) in_fifo_i (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .push_i     (s_valid_i & |s_wstrb_i),
      .push_data_i({s_wdata_i, s_wstrb_i}),
      .full_o     (in_full),
      .pop_i      (wr_pop),
      .pop_data_o (in_head),
      .empty_o    (),
      .level_o    (in_level)
   );

   sync_fifo #(.WIDTH(`BRIDGE_DATA_W), .DEPTH_LOG(`AXI_LEN_W)) out_fifo_i (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .push_i     (rd_push),
      .push_data_i(rd_push_data),
      .full_o     (),
      .pop_i      (s_valid_i & ~|s_wstrb_i),
      .pop_data_o (s_rdata_o),
      .empty_o    (out_empty),
      .level_o    (out_level)
   );

   // Burst planner
   assign avail = (dir_q == DIR_WRITE) ? in_level : MAX_BEATS - out_level;
   assign eng_ready  = (dir_q == DIR_WRITE) ? wr_ready : rd_ready;
   assign page_left  = 11'd1024 - {1'b0, cur_addr.fields.word};
   assign flush_done = flush_cnt == FLUSH_W'(`FLUSH_WAIT);

   always_comb begin
      limit = MAX_BEATS;
      if (remaining < count_t'(limit)) begin
         limit = remaining[BEAT_W-1:0];
      end
      if (page_left < 11'(limit)) begin
         limit = page_left[BEAT_W-1:0];
      end
      burst_words = (avail < limit) ? avail : limit;
   end

   // A full input FIFO or empty output FIFO always covers the limit
   assign issue = busy_q && remaining != '0 && eng_ready && burst_words != '0 &&
                  (avail >= limit || flush_done);
   assign burst_len = axi_len_t'(burst_words - 1'b1);
   assign next_word = {cur_addr.fields.page, cur_addr.fields.word} + 14'(burst_words);

   always_ff @(posedge clk_i, posedge rst_i) begin
      if (rst_i) begin
         busy_q    <= 1'b0;
         dir_q     <= DIR_READ;
         cur_addr  <= '0;
         remaining <= '0;
         flush_cnt <= '0;
         err_q     <= 1'b0;
      end else if (run_ok) begin
         busy_q    <= 1'b1;
         dir_q     <= dir_i;
         cur_addr  <= {addr_i.flat[`BRIDGE_ADDR_W-1:2], 2'b00};
         remaining <= count_i;
         flush_cnt <= '0;
         err_q     <= 1'b0;
      end else begin
         err_q <= err_q | rd_err | wr_err;
         if (issue) begin
            cur_addr  <= {next_word, 2'b00};
            remaining <= remaining - count_t'(burst_words);
            flush_cnt <= '0;
         end else if (busy_q && eng_ready && avail != '0 && !flush_done) begin
            flush_cnt <= flush_cnt + 1'b1;
         end
         // Done once the last burst has fully drained
         if (busy_q && remaining == '0 && rd_ready && wr_ready) begin
            busy_q <= 1'b0;
         end
      end
   end

   axi_read_engine rd_engine_i (
      .clk_i(clk_i), .rst_i(rst_i),
      .run_i(issue & (dir_q == DIR_READ)), .addr_i(cur_addr), .len_i(burst_len),
      .ready_o(rd_ready), .error_o(rd_err),
      .arvalid_o(arvalid_o), .arready_i(arready_i), .araddr_o(araddr_o), .arlen_o(arlen_o),
      .rvalid_i(rvalid_i), .rready_o(rready_o), .rdata_i(rdata_i), .rresp_i(rresp_i),
      .rlast_i(rlast_i), .push_o(rd_push), .push_data_o(rd_push_data)
   );

   axi_write_engine wr_engine_i (
      .clk_i(clk_i), .rst_i(rst_i),
      .run_i(issue & (dir_q == DIR_WRITE)), .addr_i(cur_addr), .len_i(burst_len),
      .ready_o(wr_ready), .error_o(wr_err),
      .awvalid_o(awvalid_o), .awready_i(awready_i), .awaddr_o(awaddr_o), .awlen_o(awlen_o),
      .wvalid_o(wvalid_o), .wready_i(wready_i), .wdata_o(wdata_o), .wstrb_o(wstrb_o),
      .wlast_o(wlast_o), .bvalid_i(bvalid_i), .bready_o(bready_o), .bresp_i(bresp_i),
      .pop_o(wr_pop), .pop_data_i(in_head[STRB_W +: `BRIDGE_DATA_W]),
      .pop_strb_i(in_head[STRB_W-1:0])
   );

endmodule

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen #(
   parameter int PERIOD_NS    = 100,
   parameter int RESET_CYCLES = 2
) (
   output logic clk_o,
   output logic rst_o
);

   initial begin
      clk_o = 1'b0;
      rst_o = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_o);
      // Release well clear of the edge and of the stimulus slot
      #(PERIOD_NS / 4) rst_o = 1'b0;
   end

   always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

// ==== test/axi_mem_model.sv ====
`timescale 1ns/1ns
`include "axi_burst_config.svh"

module axi_mem_model
   import axi_pkg::*, bridge_pkg::*;
(
   input  logic                      clk_i,
   input  logic                      rst_i,
   input  logic [3:0]                stall_i,
   input  logic                      awvalid_i,
   output logic                      awready_o,
   input  logic [`BRIDGE_ADDR_W-1:0] awaddr_i,
   input  logic                      wvalid_i,
   output logic                      wready_o,
   input  word_t                     wdata_i,
   input  strb_t                     wstrb_i,
   input  logic                      wlast_i,
   output logic                      bvalid_o,
   input  logic                      bready_i,
   output axi_resp_e                 bresp_o,
   input  logic                      arvalid_i,
   output logic                      arready_o,
   input  logic [`BRIDGE_ADDR_W-1:0] araddr_i,
   input  axi_len_t                  arlen_i,
   output logic                      rvalid_o,
   input  logic                      rready_i,
   output word_t                     rdata_o,
   output axi_resp_e                 rresp_o,
   output logic                      rlast_o
);

   localparam int WORD_AW = `BRIDGE_ADDR_W - 2;
   // Words that answer with SLVERR
   localparam logic [WORD_AW-1:0] ERR_FIRST = 14'h3F00;
   localparam logic [WORD_AW-1:0] ERR_LAST  = 14'h3F3F;

   word_t              mem [1 << WORD_AW];
   logic [WORD_AW-1:0] aw_word, ar_word, wr_word, rd_word;
   axi_len_t           ar_len, rd_left;
   word_t              w_data;
   strb_t              w_strb;
   logic               w_last;
   logic               aw_hs, w_hs, b_hs, ar_hs, r_hs;
   logic [1:0]         w_phase;
   logic               wr_err, r_busy;

   function automatic logic in_err_region(input logic [WORD_AW-1:0] w);
      return w >= ERR_FIRST && w <= ERR_LAST;
   endfunction

   // Phases 0 wait AW, 1 data, 2 response
   task automatic step_write();
      int b;
      if (b_hs) begin
         w_phase = 2'd0;
      end
      if (w_hs) begin
         for (b = 0; b < `BRIDGE_DATA_W / 8; b++) begin
            if (w_strb[b]) begin
               mem[wr_word][8*b +: 8] = w_data[8*b +: 8];
            end
         end
         wr_err  = wr_err | in_err_region(wr_word);
         wr_word = wr_word + 1'b1;
         if (w_last) begin
            w_phase = 2'd2;
         end
      end
      if (aw_hs) begin
         wr_word = aw_word;
         wr_err  = 1'b0;
         w_phase = 2'd1;
      end
      awready_o = w_phase == 2'd0 && !stall_i[0];
      wready_o  = w_phase == 2'd1 && !stall_i[1];
      bvalid_o  = w_phase == 2'd2;
      bresp_o   = wr_err ? SLVERR : OKAY;
   endtask

   task automatic step_read();
      if (r_hs) begin
         rvalid_o = 1'b0;
         if (rlast_o) begin
            r_busy = 1'b0;
         end else begin
            rd_word = rd_word + 1'b1;
            rd_left = rd_left - 1'b1;
         end
      end
      if (ar_hs) begin
         r_busy  = 1'b1;
         rd_word = ar_word;
         rd_left = ar_len;
      end
      // A beat once offered stays until taken
      if (r_busy && !rvalid_o && !stall_i[3]) begin
         rvalid_o = 1'b1;
         rdata_o  = mem[rd_word];
         rresp_o  = in_err_region(rd_word) ? SLVERR : OKAY;
         rlast_o  = rd_left == '0;
      end
      arready_o = !r_busy && !stall_i[2];
   endtask

   initial begin
      awready_o = 1'b0;
      wready_o  = 1'b0;
      bvalid_o  = 1'b0;
      bresp_o   = OKAY;
      arready_o = 1'b0;
      rvalid_o  = 1'b0;
      rdata_o   = '0;
      rresp_o   = OKAY;
      rlast_o   = 1'b0;
      w_phase   = 2'd0;
      wr_err    = 1'b0;
      r_busy    = 1'b0;
      forever begin
         // Handshakes taken mid cycle, before the edge that completes them
         @(negedge clk_i);
         aw_hs   = awvalid_i && awready_o;
         w_hs    = wvalid_i && wready_o;
         b_hs    = bvalid_o && bready_i;
         ar_hs   = arvalid_i && arready_o;
         r_hs    = rvalid_o && rready_i;
         aw_word = awaddr_i[`BRIDGE_ADDR_W-1:2];
         ar_word = araddr_i[`BRIDGE_ADDR_W-1:2];
         ar_len  = arlen_i;
         w_data  = wdata_i;
         w_strb  = wstrb_i;
         w_last  = wlast_i;
         @(posedge clk_i);
         #10;
         if (!rst_i) begin
            step_write();
            step_read();
         end
      end
   end

endmodule

// ==== test/tb_axi_burst_bridge.sv ====
`timescale 1ns/1ns
`include "axi_burst_config.svh"

module tb_axi_burst_bridge
   import axi_pkg::*, bridge_pkg::*;
();

   localparam int TIMEOUT    = 2000;
   localparam int N_TESTS    = 12;
   localparam int WORDS      = 1 << (`BRIDGE_ADDR_W - 2);
   localparam int MAX_BEATS  = 1 << `AXI_LEN_W;
   localparam int PAGE_WORDS = 1024;

   logic                      clk, rst, run, ready, error;
   dir_e                      dir;
   bridge_addr_u              start_addr;
   count_t                    count;
   logic                      s_valid, s_ready;
   word_t                     s_wdata, s_rdata;
   strb_t                     s_wstrb;
   logic                      awvalid, awready, wvalid, wready, wlast, bvalid, bready;
   logic                      arvalid, arready, rvalid, rready, rlast;
   logic [`BRIDGE_ADDR_W-1:0] awaddr, araddr;
   axi_len_t                  awlen, arlen;
   word_t                     wdata, rdata;
   strb_t                     wstrb;
   axi_resp_e                 bresp, rresp;
   logic [3:0]                stall, stall_draw;

   logic [15:0]  lfsr = 16'd14571;
   word_t        ref_mem [WORDS];
   dir_e         mon_dir;
   bridge_addr_u mon_addr;
   int           mon_left;
   int           mon_sum;

   tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(2)) clk_gen_i (.clk_o(clk), .rst_o(rst));

   axi_burst_bridge dut_i (
      .clk_i(clk), .rst_i(rst), .run_i(run), .dir_i(dir), .addr_i(start_addr),
      .count_i(count), .ready_o(ready), .error_o(error),
      .s_valid_i(s_valid), .s_wdata_i(s_wdata), .s_wstrb_i(s_wstrb),
      .s_rdata_o(s_rdata), .s_ready_o(s_ready),
      .awvalid_o(awvalid), .awready_i(awready), .awaddr_o(awaddr), .awlen_o(awlen),
      .wvalid_o(wvalid), .wready_i(wready), .wdata_o(wdata), .wstrb_o(wstrb),
      .wlast_o(wlast), .bvalid_i(bvalid), .bready_o(bready), .bresp_i(bresp),
      .arvalid_o(arvalid), .arready_i(arready), .araddr_o(araddr), .arlen_o(arlen),
      .rvalid_i(rvalid), .rready_o(rready), .rdata_i(rdata), .rresp_i(rresp),
      .rlast_i(rlast)
   );

   axi_mem_model mem_model_i (
      .clk_i(clk), .rst_i(rst), .stall_i(stall),
      .awvalid_i(awvalid), .awready_o(awready), .awaddr_i(awaddr),
      .wvalid_i(wvalid), .wready_o(wready), .wdata_i(wdata), .wstrb_i(wstrb),
      .wlast_i(wlast), .bvalid_o(bvalid), .bready_i(bready), .bresp_o(bresp),
      .arvalid_i(arvalid), .arready_o(arready), .araddr_i(araddr), .arlen_i(arlen),
      .rvalid_o(rvalid), .rready_i(rready), .rdata_o(rdata), .rresp_o(rresp),
      .rlast_o(rlast)
   );

   // x^16 + x^14 + x^13 + x^11 + 1, one step per bit handed out
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] bits;
      logic        fb;
      bits = '0;
      for (int k = 0; k < n; k++) begin
         fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         bits = {bits[30:0], fb};
      end
      return bits;
   endfunction

   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (act !== exp) begin
         stop_on_error($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
      end
   endtask

   task automatic check_error(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         stop_on_error($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
      end
   endtask

   task automatic check_count(input string name, input count_t exp, input count_t act);
      if (act !== exp) begin
         stop_on_error($sformatf("MISMATCH %s expected %0d actual %0d", name, exp, act));
      end
   endtask

   task automatic check_burst(input string name, input bridge_addr_u exp_addr,
                              input bridge_addr_u act_addr, input axi_len_t max_len,
                              input axi_len_t act_len);
      if (act_addr !== exp_addr) begin
         stop_on_error($sformatf("MISMATCH %s address expected %h actual %h",
                                 name, exp_addr.flat, act_addr.flat));
      end
      if (act_len > max_len) begin
         stop_on_error($sformatf("MISMATCH %s length expected at most %0d actual %0d",
                                 name, max_len, act_len));
      end
   endtask

   // Longest legal burst from the words left, the page end and the AXI limit
   task automatic record_burst(input dir_e d, input logic [`BRIDGE_ADDR_W-1:0] a,
                               input axi_len_t len);
      bridge_addr_u act;
      int           lim;
      act.flat = a;
      if (d != mon_dir) begin
         stop_on_error("burst seen on the channel of the other direction");
      end
      if (mon_left == 0) begin
         stop_on_error("burst issued after every word of the transfer was covered");
      end
      lim = MAX_BEATS;
      if (mon_left < lim) begin
         lim = mon_left;
      end
      if (PAGE_WORDS - int'(mon_addr.fields.word) < lim) begin
         lim = PAGE_WORDS - int'(mon_addr.fields.word);
      end
      check_burst("burst", mon_addr, act, axi_len_t'(lim - 1), len);
      mon_addr.flat = mon_addr.flat + 16'((int'(len) + 1) * 4);
      mon_left      = mon_left - (int'(len) + 1);
      mon_sum       = mon_sum + int'(len) + 1;
   endtask

   task automatic wait_host_ready(input string what);
      int tries;
      tries = 0;
      @(negedge clk);
      while (!s_ready) begin
         tries++;
         if (tries > TIMEOUT) begin
            stop_on_error({"host port never became ready for ", what});
         end
         @(negedge clk);
      end
   endtask

   task automatic start_transfer(input dir_e d, input bridge_addr_u a, input count_t n);
      run           = 1'b1;
      dir           = d;
      start_addr    = a;
      count         = n;
      mon_dir       = d;
      mon_addr.flat = {a.flat[`BRIDGE_ADDR_W-1:2], 2'b00};
      mon_left      = int'(n);
      mon_sum       = 0;
      @(posedge clk);
      #10;
      run = 1'b0;
      @(negedge clk);
      check_error("ready after run", 1'b0, ready);
      check_error("error cleared by run", 1'b0, error);
      @(posedge clk);
      #10;
   endtask

   task automatic send_words(input bridge_addr_u a, input count_t n);
      int               i;
      int               b;
      logic [13:0]      widx;
      word_t            data;
      strb_t            strb;
      for (i = 0; i < int'(n); i++) begin
         repeat (take_bits(2)) begin
            @(posedge clk);
            #10;
         end
         data = take_bits(32);
         strb = strb_t'(take_bits(4));
         // A zero strobe would mean a pop
         if (strb == '0) begin
            strb = '1;
         end
         s_valid = 1'b1;
         s_wdata = data;
         s_wstrb = strb;
         wait_host_ready("a write word");
         widx = {a.fields.page, a.fields.word} + 14'(i);
         for (b = 0; b < `BRIDGE_DATA_W / 8; b++) begin
            if (strb[b]) begin
               ref_mem[widx][8*b +: 8] = data[8*b +: 8];
            end
         end
         @(posedge clk);
         #10;
         s_valid = 1'b0;
         s_wstrb = '0;
      end
   endtask

   task automatic fetch_words(input string name, input bridge_addr_u a, input count_t n);
      int          i;
      logic [13:0] widx;
      for (i = 0; i < int'(n); i++) begin
         // Slow host pops
         repeat (take_bits(3)) begin
            @(posedge clk);
            #10;
         end
         s_valid = 1'b1;
         s_wstrb = '0;
         wait_host_ready("a read word");
         widx = {a.fields.page, a.fields.word} + 14'(i);
         check_word($sformatf("%s word %0d", name, i), ref_mem[widx], s_rdata);
         @(posedge clk);
         #10;
         s_valid = 1'b0;
      end
   endtask

   task automatic wait_transfer_done(input string name, input count_t n, input logic exp_err);
      int tries;
      tries = 0;
      @(negedge clk);
      while (!ready) begin
         tries++;
         if (tries > TIMEOUT) begin
            stop_on_error({name, " never finished, ready stayed low"});
         end
         @(negedge clk);
      end
      check_error({name, " error"}, exp_err, error);
      check_count({name, " burst words"}, n, count_t'(mon_sum));
      @(posedge clk);
      #10;
   endtask

   task automatic write_then_read(input string name, input bridge_addr_u a, input count_t n,
                                  input logic exp_err);
      start_transfer(DIR_WRITE, a, n);
      send_words(a, n);
      wait_transfer_done({name, " write"}, n, exp_err);
      start_transfer(DIR_READ, a, n);
      fetch_words({name, " read"}, a, n);
      wait_transfer_done({name, " read"}, n, exp_err);
   endtask

   // Memory stalls on awready, wready, arready and rvalid, each about one cycle in four
   always begin
      @(posedge clk);
      #5;
      stall_draw = 4'(take_bits(4));
      stall      = stall_draw & 4'(take_bits(4));
   end

   always @(negedge clk) begin
      if (!rst && awvalid && awready) begin
         record_burst(DIR_WRITE, awaddr, awlen);
      end
      if (!rst && arvalid && arready) begin
         record_burst(DIR_READ, araddr, arlen);
      end
   end

   initial begin
      int           i;
      int           t;
      int           tries;
      bridge_addr_u a;
      count_t       n;
      run        = 1'b0;
      dir        = DIR_READ;
      start_addr = '0;
      count      = '0;
      s_valid    = 1'b0;
      s_wdata    = '0;
      s_wstrb    = '0;
      stall      = '0;
      for (i = 0; i < WORDS; i++) begin
         ref_mem[i]           = word_t'(i) * 32'h9E37_79B1 + 32'h0123_4567;
         mem_model_i.mem[i] = ref_mem[i];
      end
      tries = 0;
      @(negedge clk);
      while (rst) begin
         tries++;
         if (tries > TIMEOUT) begin
            stop_on_error("reset was never released");
         end
         @(negedge clk);
      end
      check_error("reset ready", 1'b1, ready);
      check_error("reset error", 1'b0, error);
      check_error("reset valids", 1'b0, awvalid | wvalid | bready | arvalid | rready | s_ready);
      @(posedge clk);
      #10;
      for (t = 0; t < N_TESTS; t++) begin
         a.flat = 16'(take_bits(15));
         // Often start near a page end so bursts get split
         if (take_bits(2) == 0) begin
            a.flat[11:8] = 4'hF;
         end
         n = count_t'(take_bits(6) % 60 + 1);
         write_then_read($sformatf("test %0d", t), a, n, 1'b0);
      end
      a.flat = 16'hFC40;
      write_then_read("error region", a, 24, 1'b1);
      a.flat = 16'h0FE6;
      write_then_read("after error", a, 30, 1'b0);
      $display("TEST OK");
      $finish;
   end

endmodule

// ==== all.f ====
+incdir+source
source/axi_pkg.sv
source/bridge_pkg.sv
source/sync_fifo.sv
source/axi_read_engine.sv
source/axi_write_engine.sv
source/axi_burst_bridge.sv
test/tb_clock_gen.sv
test/axi_mem_model.sv
test/tb_axi_burst_bridge.sv
